// ==== hdl/icache_pkg.sv ====
package icache_pkg;

    // Address split: tag | index | offset
    localparam int TAG_BITS    = 20;
    localparam int INDEX_BITS  = 8;
    localparam int OFFSET_BITS = 4;
    localparam int ADDR_BITS   = TAG_BITS + INDEX_BITS + OFFSET_BITS;

    localparam int SETS = 1 << INDEX_BITS;
    localparam int WAYS = 4;

    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;

    // One cache line, seen whole or as bank words (word 0 at the low end)
    typedef union packed {
        logic [LINE_BITS-1:0]                      flat;
        logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] words;
    } line_u;

endpackage

// ==== hdl/icache_lookup_if.sv ====
interface icache_lookup_if #(
    parameter int NUM_WAYS = icache_pkg::WAYS
);
    import icache_pkg::*;

    logic                  en;
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;

    // Results of the lookup, one cycle after en
    logic [NUM_WAYS-1:0]   hit_way;
    line_u [NUM_WAYS-1:0]  way_line;

    modport ctrl (
        output en, index, tag,
        input  hit_way, way_line
    );

    modport tag_side (
        input  en, index, tag,
        output hit_way
    );

    modport data_side (
        input  en, index,
        output way_line
    );

endinterface

// ==== hdl/icache_fill_if.sv ====
interface icache_fill_if #(
    parameter int NUM_WAYS = icache_pkg::WAYS
);
    import icache_pkg::*;

    // One-hot, pulses for a single cycle per refill
    logic [NUM_WAYS-1:0]   we_way;
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    line_u                 line;

    modport ctrl (
        output we_way, index, tag, line
    );

    modport array (
        input  we_way, index, tag, line
    );

endinterface

// ==== hdl/icache_tag_array.sv ====
module icache_tag_array #(
    parameter int NUM_WAYS = icache_pkg::WAYS
) (
    input  logic               clk,
    input  logic               resetn,
    icache_lookup_if.tag_side  lk,
    icache_fill_if.array       fill
);
    import icache_pkg::*;

    logic [TAG_BITS-1:0]             tag_mem [NUM_WAYS][SETS];
    logic [NUM_WAYS-1:0][SETS-1:0]   valid_bits;

    logic [TAG_BITS-1:0]   tag_q [NUM_WAYS];
    logic [INDEX_BITS-1:0] idx_q;

    // Tag storage and registered read
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (fill.we_way[w]) begin
                tag_mem[w][fill.index] <= fill.tag;
            end
            if (lk.en) begin
                tag_q[w] <= tag_mem[w][lk.index];
            end
        end
        if (lk.en) begin
            idx_q <= lk.index;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (fill.we_way[w]) begin
                    valid_bits[w][fill.index] <= 1'b1;
                end
            end
        end
    end

    // Compare against the buffered request tag
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            lk.hit_way[w] = valid_bits[w][idx_q] && (tag_q[w] == lk.tag);
        end
    end

endmodule

// ==== hdl/icache_data_array.sv ====
module icache_data_array #(
    parameter int NUM_WAYS = icache_pkg::WAYS
) (
    input  logic                clk,
    icache_lookup_if.data_side  lk,
    icache_fill_if.array        fill
);
    import icache_pkg::*;

    line_u line_mem [NUM_WAYS][SETS];

    // Whole line written on refill, read out on lookup
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (fill.we_way[w]) begin
                line_mem[w][fill.index] <= fill.line;
            end
            if (lk.en) begin
                lk.way_line[w] <= line_mem[w][lk.index];
            end
        end
    end

endmodule

// ==== hdl/icache_plru.sv ====
module icache_plru #(
    parameter int NUM_WAYS = icache_pkg::WAYS
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            touch,
    input  logic [$clog2(NUM_WAYS)-1:0]     touch_way,
    input  logic [icache_pkg::INDEX_BITS-1:0] index,
    output logic [$clog2(NUM_WAYS)-1:0]     victim_way
);
    import icache_pkg::*;

    localparam int WAY_BITS = $clog2(NUM_WAYS);

    logic [SETS-1:0][NUM_WAYS-1:0] mru;

    logic [NUM_WAYS-1:0] set_bits;
    logic [NUM_WAYS-1:0] touch_bit;
    logic [NUM_WAYS-1:0] touched;

    assign set_bits  = mru[index];
    assign touch_bit = NUM_WAYS'(1) << touch_way;
    assign touched   = set_bits | touch_bit;

    // Once every way is marked, only the touched one keeps its bit
    always_ff @(posedge clk) begin
        if (!resetn) begin
            mru <= '0;
        end else if (touch) begin
            mru[index] <= (&touched) ? touch_bit : touched;
        end
    end

    // Lowest way not recently used
    always_comb begin
        victim_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_bits[w]) begin
                victim_way = WAY_BITS'(w);
            end
        end
    end

endmodule

// ==== hdl/icache_ctrl.sv ====
module icache_ctrl #(
    parameter int NUM_WAYS = icache_pkg::WAYS
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              valid,
    input  logic                              uncache,
    input  logic [icache_pkg::TAG_BITS-1:0]    tag,
    input  logic [icache_pkg::INDEX_BITS-1:0]  index,
    input  logic [icache_pkg::OFFSET_BITS-1:0] offset,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [icache_pkg::LINE_BITS-1:0]   rdata,
    output logic [3:0]                        rnum,
    output logic                              rd_req,
    output logic                              rd_type,
    output logic [icache_pkg::ADDR_BITS-1:0]   rd_addr,
    input  logic                              rd_rdy,
    input  logic                              ret_valid,
    input  logic [icache_pkg::LINE_BITS-1:0]   ret_data,
    icache_lookup_if.ctrl                     lk,
    icache_fill_if.ctrl                       fill
);
    import icache_pkg::*;

    localparam int WAY_BITS = $clog2(NUM_WAYS);

    localparam logic [5:0] IDLE    = 6'b000001;
    localparam logic [5:0] LOOKUP  = 6'b000010;
    localparam logic [5:0] REPLACE = 6'b000100;
    localparam logic [5:0] REFILL  = 6'b001000;
    localparam logic [5:0] UREQ    = 6'b010000;
    localparam logic [5:0] URESP   = 6'b100000;

    logic [5:0] state;
    logic [5:0] state_nxt;

    logic [TAG_BITS-1:0]    rb_tag;
    logic [INDEX_BITS-1:0]  rb_index;
    logic [OFFSET_BITS-1:0] rb_offset;
    logic                   rb_uncache;

    logic                accept;
    logic                hit;
    logic [WAY_BITS-1:0] hit_num;
    logic [WAY_BITS-1:0] victim_way;
    logic [WAY_BITS-1:0] rp_way;
    logic                touch;
    line_u               hit_line;
    line_u               ret_line;
    line_u               sel_line;
    logic [1:0]          word_sel;

    assign hit     = |lk.hit_way;
    assign addr_ok = valid && (state == IDLE || (state == LOOKUP && hit));
    assign accept  = valid && addr_ok;

    // Request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            rb_tag     <= tag;
            rb_index   <= index;
            rb_offset  <= offset;
            rb_uncache <= uncache;
        end
    end

    assign lk.en    = accept && !uncache;
    assign lk.index = index;
    assign lk.tag   = rb_tag;

    always_comb begin
        hit_num  = '0;
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (lk.hit_way[w]) begin
                hit_num       = WAY_BITS'(w);
                hit_line.flat = hit_line.flat | lk.way_line[w].flat;
            end
        end
    end

    // Victim is captured on the miss and marked used once memory grants
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rp_way <= '0;
        end else if (state == LOOKUP && !hit) begin
            rp_way <= victim_way;
        end
    end

    assign touch = (state == LOOKUP && hit) || (state == REPLACE && rd_rdy);

    icache_plru #(
        .NUM_WAYS (NUM_WAYS)
    ) u_plru (
        .clk        (clk),
        .resetn     (resetn),
        .touch      (touch),
        .touch_way  ((state == LOOKUP) ? hit_num : rp_way),
        .index      (rb_index),
        .victim_way (victim_way)
    );

    assign ret_line.flat = ret_data;

    assign fill.we_way = (state == REFILL && ret_valid) ? (NUM_WAYS'(1) << rp_way) : '0;
    assign fill.index  = rb_index;
    assign fill.tag    = rb_tag;
    assign fill.line   = ret_line;

    // Response
    assign word_sel = rb_offset[OFFSET_BITS-1:2];
    assign sel_line = (state == LOOKUP) ? hit_line : ret_line;

    assign data_ok = (state == LOOKUP && hit) ||
                     ((state == REFILL || state == URESP) && ret_valid);
    assign rdata   = (state == URESP) ?
                     {{(LINE_BITS - WORD_BITS){1'b0}}, ret_line.words[0]} :
                     sel_line.flat >> (word_sel * WORD_BITS);
    assign rnum    = rb_uncache ? 4'd1 : 4'(WORDS_PER_LINE) - {2'b00, word_sel};

    assign rd_req  = (state == REPLACE) || (state == UREQ);
    assign rd_type = !rb_uncache;
    assign rd_addr = rb_uncache ? {rb_tag, rb_index, rb_offset} :
                                  {rb_tag, rb_index, {OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = uncache ? UREQ : LOOKUP;
                end
            end
            LOOKUP: begin
                if (!hit) begin
                    state_nxt = REPLACE;
                end else if (accept) begin
                    state_nxt = uncache ? UREQ : LOOKUP;
                end else begin
                    state_nxt = IDLE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    state_nxt = IDLE;
                end
            end
            UREQ: begin
                if (rd_rdy) begin
                    state_nxt = URESP;
                end
            end
            URESP: begin
                if (ret_valid) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

endmodule

// ==== hdl/icache.sv ====
module icache #(
    parameter int NUM_WAYS = icache_pkg::WAYS
) (
    input  logic                              clk,
    input  logic                              resetn,
    // CPU fetch port
    input  logic                              valid,
    input  logic                              uncache,
    input  logic [icache_pkg::TAG_BITS-1:0]    tag,
    input  logic [icache_pkg::INDEX_BITS-1:0]  index,
    input  logic [icache_pkg::OFFSET_BITS-1:0] offset,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [icache_pkg::LINE_BITS-1:0]   rdata,
    output logic [3:0]                        rnum,
    // Memory read port
    output logic                              rd_req,
    output logic                              rd_type,
    output logic [icache_pkg::ADDR_BITS-1:0]   rd_addr,
    input  logic                              rd_rdy,
    input  logic                              ret_valid,
    input  logic [icache_pkg::LINE_BITS-1:0]   ret_data
);

    icache_lookup_if #(.NUM_WAYS(NUM_WAYS)) lk_if ();
    icache_fill_if   #(.NUM_WAYS(NUM_WAYS)) fill_if ();

    icache_ctrl #(
        .NUM_WAYS (NUM_WAYS)
    ) u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .uncache   (uncache),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rnum      (rnum),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .lk        (lk_if.ctrl),
        .fill      (fill_if.ctrl)
    );

    icache_tag_array #(
        .NUM_WAYS (NUM_WAYS)
    ) u_tag_array (
        .clk    (clk),
        .resetn (resetn),
        .lk     (lk_if.tag_side),
        .fill   (fill_if.array)
    );

    icache_data_array #(
        .NUM_WAYS (NUM_WAYS)
    ) u_data_array (
        .clk  (clk),
        .lk   (lk_if.data_side),
        .fill (fill_if.array)
    );

endmodule

// ==== testbench/icache_mem_model.sv ====
module icache_mem_model #(
    parameter logic [31:0] SEED    = 32'h1ea8_c3cc,
    parameter logic [31:0] PAT_KEY = 32'h5a3c_96e1
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            rd_req,
    input  logic [icache_pkg::ADDR_BITS-1:0] rd_addr,
    output logic                            rd_rdy,
    output logic                            ret_valid,
    output logic [icache_pkg::LINE_BITS-1:0] ret_data
);
    import icache_pkg::*;

    integer seed;

    function automatic logic [31:0] pattern_word(input logic [31:0] a);
        return (a ^ PAT_KEY) + {a[15:0], a[31:16]};
    endfunction

    // Wait of 0 to 3 cycles
    task automatic random_gap();
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);
    endtask

    task automatic serve_read();
        logic [ADDR_BITS-1:0] base;
        random_gap();
        base   = rd_addr;
        rd_rdy = 1'b1;
        @(negedge clk);
        rd_rdy = 1'b0;
        random_gap();
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            ret_data[i*WORD_BITS +: WORD_BITS] = pattern_word(base + 32'(4 * i));
        end
        ret_valid = 1'b1;
        @(negedge clk);
        ret_valid = 1'b0;
    endtask

    initial begin
        seed      = SEED;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (resetn && rd_req) begin
                serve_read();
            end
        end
    end

endmodule

// ==== testbench/tb_icache.sv ====
module tb_icache;
    import icache_pkg::*;

    localparam logic [31:0] SEED       = 32'h1ea8_c3cc;
    localparam logic [31:0] PAT_KEY    = 32'h5a3c_96e1;
    localparam int          WAIT_LIMIT = 200;
    // Five tags for one set with hits mixed between the misses
    localparam logic [TAG_BITS-1:0] SET_SEQ [13] = '{
        20'ha0001, 20'hb0002, 20'ha0001, 20'hc0003, 20'hd0004, 20'ha0001, 20'hb0002,
        20'he0005, 20'hc0003, 20'hb0002, 20'hd0004, 20'he0005, 20'ha0001
    };

    logic                   clk;
    logic                   resetn;
    logic                   valid;
    logic                   uncache;
    logic                   addr_ok;
    logic                   data_ok;
    logic                   rd_req;
    logic                   rd_type;
    logic                   rd_rdy;
    logic                   ret_valid;
    logic [TAG_BITS-1:0]    tag;
    logic [INDEX_BITS-1:0]  index;
    logic [OFFSET_BITS-1:0] offset;
    logic [LINE_BITS-1:0]   rdata;
    logic [LINE_BITS-1:0]   ret_data;
    logic [3:0]             rnum;
    logic [ADDR_BITS-1:0]   rd_addr;

    // Expected responses in acceptance order
    logic [LINE_BITS-1:0] exp_rdata [64];
    logic [3:0]           exp_rnum  [64];
    logic [ADDR_BITS-1:0] exp_raddr [64];
    bit                   exp_hit   [64];
    bit                   exp_unc   [64];
    int                   exp_cycle [64];
    logic [5:0]           rd_ptr;
    logic [5:0]           wr_ptr;
    int                   cycle;
    bit                   reset_seen;

    // Reference cache state
    logic [TAG_BITS-1:0] ref_tag   [SETS][WAYS];
    bit [WAYS-1:0]       ref_valid [SETS];
    bit [WAYS-1:0]       ref_mru   [SETS];

    icache u_icache (.*);

    icache_mem_model #(.SEED(SEED), .PAT_KEY(PAT_KEY)) u_mem (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!resetn) begin
            reset_seen <= 1'b1;
        end
        if (data_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    task automatic end_in_failure(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        end_in_failure($sformatf("MISMATCH at time %0t: %s", $time, msg));
    endtask

    assert property (@(posedge clk) (reset_seen && !resetn) || $rose(resetn) |->
                     !data_ok && !rd_req)
        else report_mismatch("data_ok or rd_req high around reset");
    assert property (@(posedge clk) !valid |-> !addr_ok)
        else report_mismatch("addr_ok high while valid is low");
    // Requests are only issued when the cache can take them at once
    assert property (@(posedge clk) disable iff (!resetn) valid |-> addr_ok)
        else report_mismatch("request not accepted in its first cycle");
    assert property (@(posedge clk) disable iff (!resetn) data_ok |-> rd_ptr != wr_ptr &&
                     rdata == exp_rdata[rd_ptr] && rnum == exp_rnum[rd_ptr])
        else report_mismatch("rdata or rnum differs from the expected response");
    assert property (@(posedge clk) disable iff (!resetn)
                     data_ok && exp_hit[rd_ptr] |-> cycle == exp_cycle[rd_ptr] + 1)
        else report_mismatch("hit not answered one cycle after acceptance");
    assert property (@(posedge clk) disable iff (!resetn)
                     (data_ok && !exp_hit[rd_ptr]) || ret_valid |-> data_ok && ret_valid)
        else report_mismatch("data_ok and ret_valid differ on a memory response");
    assert property (@(posedge clk) disable iff (!resetn) rd_req |-> rd_ptr != wr_ptr &&
                     !exp_hit[rd_ptr] && rd_type == !exp_unc[rd_ptr] &&
                     rd_addr == exp_raddr[rd_ptr])
        else report_mismatch("unexpected rd_req, rd_type or rd_addr");
    assert property (@(posedge clk) disable iff (!resetn)
                     rd_req && !rd_rdy |=> rd_req && $stable(rd_addr) && $stable(rd_type))
        else report_mismatch("memory request changed before rd_rdy");

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return (a ^ PAT_KEY) + {a[15:0], a[31:16]};
    endfunction

    function automatic logic [ADDR_BITS-1:0] line_addr(input logic [TAG_BITS-1:0] t,
                                                       input logic [INDEX_BITS-1:0] s,
                                                       input int w);
        return {t, s, 2'(w), 2'b00};
    endfunction

    // Reference lookup with the MRU-bit update
    task automatic model_lookup(input logic [ADDR_BITS-1:0] addr, output bit hit);
        int set_idx;
        int way;
        bit found;
        bit [WAYS-1:0] own;
        bit [WAYS-1:0] others;
        set_idx = addr[11:4];
        hit     = 1'b0;
        way     = 0;
        found   = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == addr[31:12]) begin
                hit = 1'b1;
                way = w;
            end
        end
        // Victim is the first way from way 0 up with a clear MRU bit
        if (!hit) begin
            for (int w = 0; w < WAYS; w++) begin
                if (!found && !ref_mru[set_idx][w]) begin
                    found = 1'b1;
                    way   = w;
                end
            end
            ref_tag[set_idx][way]   = addr[31:12];
            ref_valid[set_idx][way] = 1'b1;
        end
        own      = '0;
        own[way] = 1'b1;
        others   = ~own;
        // All other ways already marked starts a new round
        if ((ref_mru[set_idx] & others) == others) begin
            ref_mru[set_idx] = own;
        end else begin
            ref_mru[set_idx][way] = 1'b1;
        end
    endtask

    // Drives one request and returns in its acceptance cycle
    task automatic fetch(input logic [ADDR_BITS-1:0] addr, input bit unc);
        bit hit;
        int wsel;
        int t;
        hit  = 1'b0;
        wsel = addr[3:2];
        t    = 0;
        if (!unc) begin
            model_lookup(addr, hit);
        end
        @(negedge clk);
        valid   = 1'b1;
        uncache = unc;
        tag     = addr[31:12];
        index   = addr[11:4];
        offset  = addr[3:0];
        exp_rdata[wr_ptr] = '0;
        if (unc) begin
            exp_rdata[wr_ptr][31:0] = mem_word(addr);
            exp_rnum[wr_ptr]        = 4'd1;
            exp_raddr[wr_ptr]       = addr;
        end else begin
            for (int j = 0; j < WORDS_PER_LINE - wsel; j++) begin
                exp_rdata[wr_ptr][j*WORD_BITS +: WORD_BITS] =
                    mem_word({addr[31:4], 4'h0} + 32'(4 * (wsel + j)));
            end
            exp_rnum[wr_ptr]  = 4'(WORDS_PER_LINE - wsel);
            exp_raddr[wr_ptr] = {addr[31:4], 4'h0};
        end
        exp_hit[wr_ptr] = hit;
        exp_unc[wr_ptr] = unc;
        @(posedge clk);
        while (!addr_ok) begin
            t++;
            if (t > WAIT_LIMIT) begin
                end_in_failure("Timed out waiting for addr_ok");
            end
            @(posedge clk);
        end
        exp_cycle[wr_ptr] = cycle;
        wr_ptr = wr_ptr + 1'b1;
    endtask

    task automatic release_and_drain();
        int t;
        t = 0;
        @(negedge clk);
        valid = 1'b0;
        while (rd_ptr != wr_ptr) begin
            t++;
            if (t > WAIT_LIMIT) begin
                end_in_failure("Timed out waiting for data_ok");
            end
            @(posedge clk);
        end
    endtask

    initial begin
        clk        = 1'b0;
        resetn     = 1'b0;
        valid      = 1'b0;
        uncache    = 1'b0;
        tag        = '0;
        index      = '0;
        offset     = '0;
        rd_ptr     = '0;
        wr_ptr     = '0;
        cycle      = 0;
        reset_seen = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        repeat (2) @(negedge clk);

        // Cold misses then hits on the refilled lines
        fetch(line_addr(20'h12345, 8'h10, 2), 1'b0);
        release_and_drain();
        fetch(line_addr(20'h12345, 8'h10, 0), 1'b0);
        release_and_drain();
        fetch(line_addr(20'h6789a, 8'h11, 3), 1'b0);
        release_and_drain();

        // Hits on successive cycles closed by an uncached read of a cached line
        for (int i = 0; i < 6; i++) begin
            fetch(line_addr((i % 2) ? 20'h6789a : 20'h12345, (i % 2) ? 8'h11 : 8'h10, i % 4),
                  1'b0);
        end
        fetch(line_addr(20'h12345, 8'h10, 2), 1'b1);
        release_and_drain();

        // Uncached line is not allocated
        fetch(line_addr(20'h0beef, 8'h20, 1), 1'b1);
        release_and_drain();
        fetch(line_addr(20'h0beef, 8'h20, 1), 1'b0);
        release_and_drain();

        for (int i = 0; i < 13; i++) begin
            fetch(line_addr(SET_SEQ[i], 8'h40, i % 4), 1'b0);
            release_and_drain();
        end

        if (rd_ptr != wr_ptr) begin
            end_in_failure("Responses still outstanding at the end of the test");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
hdl/icache_pkg.sv
hdl/icache_lookup_if.sv
hdl/icache_fill_if.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_plru.sv
hdl/icache_ctrl.sv
hdl/icache.sv
testbench/icache_mem_model.sv
testbench/tb_icache.sv
